// File: files.f
+incdir+rtl
rtl/fifo_data_pkg.sv
rtl/fifo_ctrl_pkg.sv
rtl/fifo_storage.sv
rtl/fifo_write_ctrl.sv
rtl/fifo_read_ctrl.sv
rtl/fifo_occupancy.sv
rtl/sync_fifo.sv
sim/tb_sync_fifo.sv

// File: rtl/fifo_consts.svh
// fifo sizing macros: word width, depth, pointer, level and count widths
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// one stored word
`define FIFO_DATA_W 8

// usable entries, power of two so pointers wrap on their own
`define FIFO_DEPTH 16

// storage index width, log2 of depth
`define FIFO_ADDR_W 4

// level must hold 0 up to depth inclusive
`define FIFO_LEVEL_W 5

// coarse count port, level shifted right by level_w - count_w
`define FIFO_COUNT_W 3

`endif

// File: rtl/fifo_ctrl_pkg.sv
// packed structs for storage requests, fill flags and transfer responses
`default_nettype none

package fifo_ctrl_pkg;
  import fifo_data_pkg::*;

  // write request into storage, strobe is also the accept pulse
  typedef struct packed {
    logic  wr;     // accepted write this cycle
    addr_t addr;   // write pointer
    data_t data;   // word to store
  } wr_req_t;

  // read request, strobe doubles as read accept
  typedef struct packed {
    logic  rd;     // accepted read this cycle
    addr_t addr;   // read pointer
  } rd_req_t;

  // registered fill flags
  typedef struct packed {
    logic full;          // level == depth
    logic almost_full;   // level >= depth-1
    logic empty;         // level == 0
    logic almost_empty;  // level <= 1
  } fill_flags_t;

  // per-operation strobes, one cycle after the sampled enable
  typedef struct packed {
    logic wr_ack;
    logic wr_err;
    logic rd_ack;
    logic rd_err;
  } xfer_resp_t;

endpackage : fifo_ctrl_pkg

`default_nettype wire

// File: rtl/fifo_data_pkg.sv
// vector typedefs for fifo data, storage address, fill level and coarse count
`default_nettype none

`include "fifo_consts.svh"

package fifo_data_pkg;

  // payload word
  typedef logic [`FIFO_DATA_W-1:0] data_t;

  // register file index, wraps at depth
  typedef logic [`FIFO_ADDR_W-1:0] addr_t;

  // words held, 0..depth
  typedef logic [`FIFO_LEVEL_W-1:0] level_t;

  // level >> 2, so full reads as 4
  typedef logic [`FIFO_COUNT_W-1:0] count_t;

endpackage : fifo_data_pkg

`default_nettype wire

// File: rtl/fifo_occupancy.sv
// fill level counter, registered full/almost/empty flags and scaled count
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_occupancy
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  wire         RD_CLK,
  input  wire         AINIT,
  input  wr_req_t     wr_req_i,   // strobe = accepted write
  input  rd_req_t     rd_req_i,   // strobe = accepted read
  output fill_flags_t flags_o,
  output count_t      count_o
);

  localparam int COUNT_SHIFT = `FIFO_LEVEL_W - `FIFO_COUNT_W;

  level_t      level_q;      // words held now
  level_t      level_nxt;    // words held after this edge
  fill_flags_t flags_nxt;
  count_t      count_nxt;
  fill_flags_t flags_q;
  count_t      count_q;

  // accept already decided in the controllers, just count strobes
  always_comb
  begin
    case ({wr_req_i.wr, rd_req_i.rd})
      2'b10:   level_nxt = level_q + level_t'(1);
      2'b01:   level_nxt = level_q - level_t'(1);
      default: level_nxt = level_q;  // none, or both cancel out
    endcase
  end

  // flags from the next level so they line up with the strobes
  always_comb
  begin
    flags_nxt.full         = (level_nxt == level_t'(`FIFO_DEPTH));
    flags_nxt.almost_full  = (level_nxt >= level_t'(`FIFO_DEPTH - 1));
    flags_nxt.empty        = (level_nxt == level_t'(0));
    flags_nxt.almost_empty = (level_nxt <= level_t'(1));
  end

  // top bits of the level, 16 -> 4
  assign count_nxt = count_t'(level_nxt >> COUNT_SHIFT);

  always_ff @(posedge RD_CLK or posedge AINIT)
  begin
    if (AINIT)
      level_q <= '0;
    else
      level_q <= level_nxt;
  end

  // all flags high out of reset
  // full drops at the first edge, so that edge rejects writes
  always_ff @(posedge RD_CLK or posedge AINIT)
  begin
    if (AINIT)
    begin
      flags_q <= '1;
      count_q <= '0;
    end
    else
    begin
      flags_q <= flags_nxt;
      count_q <= count_nxt;
    end
  end

  assign flags_o = flags_q;
  assign count_o = count_q;

endmodule : fifo_occupancy

`default_nettype wire

// File: rtl/fifo_read_ctrl.sv
// read pointer, read accept against the empty flag, rd_ack and rd_err strobes
`timescale 1ns/1ps
`default_nettype none

module fifo_read_ctrl
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  wire         RD_CLK,
  input  wire         AINIT,
  input  wire         rd_en_i,
  input  fill_flags_t flags_i,    // only empty is looked at
  output rd_req_t     rd_req_o,   // to storage and occupancy
  output logic        rd_ack_o,
  output logic        rd_err_o
);

  addr_t rd_ptr_q;     // oldest word
  logic  rd_accept;

  // read needs at least one word held
  assign rd_accept = rd_en_i & ~flags_i.empty;

  always_comb
  begin
    rd_req_o.rd   = rd_accept;
    rd_req_o.addr = rd_ptr_q;
  end

  // advance past the word being read
  always_ff @(posedge RD_CLK or posedge AINIT)
  begin
    if (AINIT)
      rd_ptr_q <= '0;
    else if (rd_accept)
      rd_ptr_q <= rd_ptr_q + addr_t'(1);  // natural wrap
  end

  // ack lines up with the new dout
  always_ff @(posedge RD_CLK or posedge AINIT)
  begin
    if (AINIT)
    begin
      rd_ack_o <= 1'b0;
      rd_err_o <= 1'b0;
    end
    else
    begin
      rd_ack_o <= rd_accept;
      rd_err_o <= rd_en_i & flags_i.empty;  // underflow attempt
    end
  end

endmodule : fifo_read_ctrl

`default_nettype wire

// File: rtl/fifo_storage.sv
// two-port register file holding fifo words, registered read data
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_storage
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  wire     RD_CLK,
  input  wire     AINIT,
  input  wr_req_t wr_req_i,   // from write controller
  input  rd_req_t rd_req_i,   // from read controller
  output data_t   dout_o      // word of the last accepted read
);

  data_t mem_q [`FIFO_DEPTH];  // payload only, no reset
  data_t dout_q;

  // write port
  always_ff @(posedge RD_CLK)
  begin
    if (wr_req_i.wr)
      mem_q[wr_req_i.addr] <= wr_req_i.data;
  end

  // read port, same address as a write only when empty so no bypass
  always_ff @(posedge RD_CLK or posedge AINIT)
  begin
    if (AINIT)
      dout_q <= '0;
    else if (rd_req_i.rd)
      dout_q <= mem_q[rd_req_i.addr];  // holds between reads
  end

  assign dout_o = dout_q;

endmodule : fifo_storage

`default_nettype wire

// File: rtl/fifo_write_ctrl.sv
// write pointer, write accept against the full flag, wr_ack and wr_err strobes
`timescale 1ns/1ps
`default_nettype none

module fifo_write_ctrl
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  wire         RD_CLK,
  input  wire         AINIT,
  input  wire         wr_en_i,
  input  data_t       din_i,
  input  fill_flags_t flags_i,    // only full is looked at
  output wr_req_t     wr_req_o,   // to storage and occupancy
  output logic        wr_ack_o,
  output logic        wr_err_o
);

  addr_t wr_ptr_q;     // next slot to write
  logic  wr_accept;    // enable with room left

  // full is registered, so it stays high for the cycle after reset
  assign wr_accept = wr_en_i & ~flags_i.full;

  // request is combinational, the storage registers it
  always_comb
  begin
    wr_req_o.wr   = wr_accept;
    wr_req_o.addr = wr_ptr_q;
    wr_req_o.data = din_i;
  end

  // pointer wraps at depth by width
  always_ff @(posedge RD_CLK or posedge AINIT)
  begin
    if (AINIT)
      wr_ptr_q <= '0;
    else if (wr_accept)
      wr_ptr_q <= wr_ptr_q + addr_t'(1);
  end

  // strobes for the write sampled at this edge
  always_ff @(posedge RD_CLK or posedge AINIT)
  begin
    if (AINIT)
    begin
      wr_ack_o <= 1'b0;
      wr_err_o <= 1'b0;
    end
    else
    begin
      wr_ack_o <= wr_accept;
      wr_err_o <= wr_en_i & flags_i.full;  // rejected, word dropped
    end
  end

endmodule : fifo_write_ctrl

`default_nettype wire

// File: rtl/sync_fifo.sv
// synchronous 16x8 fifo top: storage, write and read control, occupancy
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
(
  input  wire    RD_CLK,
  input  wire    AINIT,
  input  data_t  din_i,
  input  wire    wr_en_i,
  input  wire    rd_en_i,
  output data_t  dout_o,
  output logic   full_o,
  output logic   almost_full_o,
  output logic   empty_o,
  output logic   almost_empty_o,
  output logic   wr_ack_o,
  output logic   wr_err_o,
  output logic   rd_ack_o,
  output logic   rd_err_o,
  output count_t count_o
);

  wr_req_t     wr_req;   // write ctrl -> storage, occupancy
  rd_req_t     rd_req;   // read ctrl -> storage, occupancy
  fill_flags_t flags;    // occupancy -> both ctrls, ports

  fifo_write_ctrl fifo_write_ctrl_inst (
    .RD_CLK   (RD_CLK),
    .AINIT    (AINIT),
    .wr_en_i  (wr_en_i),
    .din_i    (din_i),
    .flags_i  (flags),
    .wr_req_o (wr_req),
    .wr_ack_o (wr_ack_o),
    .wr_err_o (wr_err_o)
  );

  fifo_read_ctrl fifo_read_ctrl_inst (
    .RD_CLK   (RD_CLK),
    .AINIT    (AINIT),
    .rd_en_i  (rd_en_i),
    .flags_i  (flags),
    .rd_req_o (rd_req),
    .rd_ack_o (rd_ack_o),
    .rd_err_o (rd_err_o)
  );

  fifo_storage fifo_storage_inst (
    .RD_CLK   (RD_CLK),
    .AINIT    (AINIT),
    .wr_req_i (wr_req),
    .rd_req_i (rd_req),
    .dout_o   (dout_o)
  );

  fifo_occupancy fifo_occupancy_inst (
    .RD_CLK   (RD_CLK),
    .AINIT    (AINIT),
    .wr_req_i (wr_req),
    .rd_req_i (rd_req),
    .flags_o  (flags),
    .count_o  (count_o)
  );

  // flatten flag struct onto ports
  assign full_o         = flags.full;
  assign almost_full_o  = flags.almost_full;
  assign empty_o        = flags.empty;
  assign almost_empty_o = flags.almost_empty;

endmodule : sync_fifo

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the sync_fifo testbench with verilator, run it, scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
  -f files.f \
  --top-module tb_sync_fifo \
  -Mdir obj_dir \
  -o tb_sync_fifo

./obj_dir/tb_sync_fifo | tee "$LOG"

if grep -q "Finished with errors" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
echo "simulation passed"

// File: sim/tb_sync_fifo.sv
// sync_fifo testbench with clock, reset, directed table, lfsr random phase, queue model and compares
`timescale 1ns/1ps
`default_nettype none

`include "fifo_consts.svh"

module tb_sync_fifo
  import fifo_data_pkg::*;
  import fifo_ctrl_pkg::*;
();

  localparam int RESET_CYCLES  = 4;
  localparam int RESET_TIMEOUT = 20;    // cycles to see the reset state
  localparam int RANDOM_CYCLES = 400;

  // one directed step with stimulus and expected results
  typedef struct packed {
    logic        wr_en;
    data_t       din;
    logic        rd_en;
    xfer_resp_t  resp;
    fill_flags_t flags;
    count_t      count;
    data_t       dout;
  } row_t;

  logic   RD_CLK = 1'b0;
  logic   AINIT;
  data_t  din;
  logic   wr_en;
  logic   rd_en;
  data_t  dout;
  logic   full;
  logic   almost_full;
  logic   empty;
  logic   almost_empty;
  logic   wr_ack;
  logic   wr_err;
  logic   rd_ack;
  logic   rd_err;
  count_t count;

  row_t  table_q [$];   // directed rows
  string name_q  [$];   // row names, same index

  // reference model state
  data_t       model_q [$];
  fill_flags_t model_flags;
  data_t       model_dout;
  xfer_resp_t  model_resp;
  count_t      model_count;

  logic [31:0] lfsr_state = 32'h78f7_b22f;

  int resp_errs    = 0;
  int flag_errs    = 0;
  int count_errs   = 0;
  int data_errs    = 0;
  int timeout_errs = 0;

  always #5 RD_CLK = ~RD_CLK;   // 10 ns period

  sync_fifo sync_fifo_inst (
    .RD_CLK         (RD_CLK),
    .AINIT          (AINIT),
    .din_i          (din),
    .wr_en_i        (wr_en),
    .rd_en_i        (rd_en),
    .dout_o         (dout),
    .full_o         (full),
    .almost_full_o  (almost_full),
    .empty_o        (empty),
    .almost_empty_o (almost_empty),
    .wr_ack_o       (wr_ack),
    .wr_err_o       (wr_err),
    .rd_ack_o       (rd_ack),
    .rd_err_o       (rd_err),
    .count_o        (count)
  );

  function automatic xfer_resp_t make_resp(input logic wa, input logic we,
                                           input logic ra, input logic re);
    xfer_resp_t r;
    r.wr_ack = wa;
    r.wr_err = we;
    r.rd_ack = ra;
    r.rd_err = re;
    return r;
  endfunction

  // flag rules on a word count
  function automatic fill_flags_t flags_for_level(input level_t lv);
    fill_flags_t f;
    int          n;
    n              = int'(lv);
    f.full         = (n == `FIFO_DEPTH);
    f.almost_full  = (n + 1 >= `FIFO_DEPTH);   // one slot left or none
    f.empty        = (n == 0);
    f.almost_empty = (n < 2);
    return f;
  endfunction

  function automatic count_t count_for_level(input level_t lv);
    int n;
    n = int'(lv);
    return count_t'(n / 4);   // four words per step, 16 reads as 4
  endfunction

  function automatic data_t pattern_word(input int k);
    return data_t'(k * 37 + 33);   // odd step keeps words distinct
  endfunction

  // right shifting galois lfsr
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hb4bc_d35c;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic xfer_resp_t actual_resp();
    return make_resp(wr_ack, wr_err, rd_ack, rd_err);
  endfunction

  function automatic fill_flags_t actual_flags();
    fill_flags_t f;
    f.full         = full;
    f.almost_full  = almost_full;
    f.empty        = empty;
    f.almost_empty = almost_empty;
    return f;
  endfunction

  // accept from the registered flags then update level, flags and count
  task automatic model_step(input logic wr, input data_t d, input logic rd);
    logic   wr_ok;
    logic   rd_ok;
    level_t lv;
    wr_ok = wr & ~model_flags.full;
    rd_ok = rd & ~model_flags.empty;
    model_resp = make_resp(wr_ok, wr & model_flags.full, rd_ok, rd & model_flags.empty);
    if (rd_ok)
      model_dout = model_q.pop_front();   // oldest word
    if (wr_ok)
      model_q.push_back(d);
    lv = level_t'(model_q.size());
    model_flags = flags_for_level(lv);
    model_count = count_for_level(lv);
  endtask

  // entered on a falling edge and returns on the next one
  task automatic drive_cycle(input logic wr, input data_t d, input logic rd);
    wr_en = wr;
    din   = d;
    rd_en = rd;
    model_step(wr, d, rd);
    @(posedge RD_CLK);
    @(negedge RD_CLK);   // results settled here
  endtask

  task automatic check_resp(input string name, input xfer_resp_t exp_v,
                            input xfer_resp_t act_v);
    if (act_v !== exp_v)
    begin
      resp_errs++;
      $display("ERR %s resp expected %b actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_flags(input string name, input fill_flags_t exp_v,
                             input fill_flags_t act_v);
    if (act_v !== exp_v)
    begin
      flag_errs++;
      $display("ERR %s flags expected %b actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_count(input string name, input count_t exp_v, input count_t act_v);
    if (act_v !== exp_v)
    begin
      count_errs++;
      $display("ERR %s count expected %0d actual %0d", name, exp_v, act_v);
    end
  endtask

  task automatic check_data(input string name, input data_t exp_v, input data_t act_v);
    if (act_v !== exp_v)
    begin
      data_errs++;
      $display("ERR %s dout expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_outputs(input string name, input xfer_resp_t r, input fill_flags_t f,
                               input count_t c, input data_t d);
    check_resp(name, r, actual_resp());
    check_flags(name, f, actual_flags());
    check_count(name, c, count);
    check_data(name, d, dout);
  endtask

  // flags and count follow from the expected level
  task automatic push_row(input string name, input logic wr, input data_t d, input logic rd,
                          input xfer_resp_t r, input int lvl, input data_t q);
    row_t row;
    row.wr_en = wr;
    row.din   = d;
    row.rd_en = rd;
    row.resp  = r;
    row.flags = flags_for_level(level_t'(lvl));
    row.count = count_for_level(level_t'(lvl));
    row.dout  = q;
    table_q.push_back(row);
    name_q.push_back(name);
  endtask

  task automatic build_table();
    xfer_resp_t w_ack;
    xfer_resp_t r_ack;
    w_ack = make_resp(1'b1, 1'b0, 1'b0, 1'b0);
    r_ack = make_resp(1'b0, 1'b0, 1'b1, 1'b0);
    // full still high from reset so the write is dropped
    push_row("release_wr", 1'b1, 8'ha5, 1'b0, make_resp(1'b0, 1'b1, 1'b0, 1'b0), 0, 8'h00);
    for (int k = 0; k < 16; k++)
      push_row($sformatf("fill_%0d", k), 1'b1, pattern_word(k), 1'b0, w_ack, k + 1, 8'h00);
    push_row("overflow", 1'b1, 8'hee, 1'b0, make_resp(1'b0, 1'b1, 1'b0, 1'b0), 16, 8'h00);
    for (int k = 0; k < 16; k++)   // write order back out
      push_row($sformatf("drain_%0d", k), 1'b0, 8'h00, 1'b1, r_ack, 15 - k, pattern_word(k));
    push_row("underflow", 1'b0, 8'h00, 1'b1, make_resp(1'b0, 1'b0, 1'b0, 1'b1), 0,
             pattern_word(15));   // dout holds
    for (int k = 0; k < 8; k++)
      push_row($sformatf("mid_fill_%0d", k), 1'b1, pattern_word(16 + k), 1'b0, w_ack, k + 1,
               pattern_word(15));
    for (int k = 0; k < 4; k++)    // level stays at 8
      push_row($sformatf("mid_both_%0d", k), 1'b1, pattern_word(24 + k), 1'b1,
               make_resp(1'b1, 1'b0, 1'b1, 1'b0), 8, pattern_word(16 + k));
    for (int k = 0; k < 8; k++)
      push_row($sformatf("top_fill_%0d", k), 1'b1, pattern_word(28 + k), 1'b0, w_ack, 9 + k,
               pattern_word(19));
    // write rejected and read taken while full
    push_row("full_both", 1'b1, 8'h77, 1'b1, make_resp(1'b0, 1'b1, 1'b1, 1'b0), 15,
             pattern_word(20));
  endtask

  task automatic wait_reset_state(output logic ok, output int used);
    ok   = 1'b0;
    used = 0;
    while (!ok && used < RESET_TIMEOUT)
    begin
      @(negedge RD_CLK);
      used++;
      ok = (empty === 1'b1);   // reset reached the flag registers
    end
  endtask

  task automatic finish_run();
    int total;
    total = resp_errs + flag_errs + count_errs + data_errs + timeout_errs;
    $display("errors: resp %0d flags %0d count %0d data %0d timeout %0d total %0d",
             resp_errs, flag_errs, count_errs, data_errs, timeout_errs, total);
    if (total == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  endtask

  initial
  begin
    logic        reset_ok;
    int          reset_used;
    logic [31:0] bits;
    logic        wr_r;
    logic        rd_r;
    data_t       din_r;
    AINIT = 1'b1;
    wr_en = 1'b0;
    rd_en = 1'b0;
    din   = '0;
    model_flags = '1;   // reset state of the flag registers
    model_dout  = '0;
    model_resp  = '0;
    model_count = '0;
    build_table();
    wait_reset_state(reset_ok, reset_used);
    if (!reset_ok)
    begin
      timeout_errs++;
      $display("timed out waiting for the DUT to report empty during reset");
      finish_run();
    end
    else
    begin
      repeat (RESET_CYCLES - reset_used) @(negedge RD_CLK);
      check_outputs("reset", '0, '1, '0, '0);
      AINIT = 1'b0;   // row 0 lands on the first edge after release
      foreach (table_q[i])
      begin
        drive_cycle(table_q[i].wr_en, table_q[i].din, table_q[i].rd_en);
        check_outputs(name_q[i], table_q[i].resp, table_q[i].flags, table_q[i].count,
                      table_q[i].dout);
      end
      for (int n = 0; n < RANDOM_CYCLES; n++)
      begin
        bits = take_bits(2);
        // blocks of 100 lean to reads then to writes
        if ((n / 100) % 2 == 0)
        begin
          rd_r = bits[0] | bits[1];
          bits = take_bits(1);
          wr_r = bits[0];
        end
        else
        begin
          wr_r = bits[0] | bits[1];
          bits = take_bits(1);
          rd_r = bits[0];
        end
        din_r = data_t'(take_bits(8));
        drive_cycle(wr_r, din_r, rd_r);
        check_outputs($sformatf("random_%0d", n), model_resp, model_flags, model_count,
                      model_dout);
      end
      wr_en = 1'b0;
      rd_en = 1'b0;
      finish_run();
    end
  end

endmodule : tb_sync_fifo

`default_nettype wire
